/* hist_pkg.sv */
package hist_pkg;

    // frame geometry
    localparam int IMG_W = 8;
    localparam int IMG_H = 8;
    localparam int POS_W = 3;
    localparam logic [POS_W-1:0] LAST_COL = POS_W'(IMG_W - 1);
    localparam logic [POS_W-1:0] LAST_ROW = POS_W'(IMG_H - 1);

    // pixel and feature widths
    localparam int PIX_W = 8;
    localparam int FEAT_W = 4;
    localparam logic [PIX_W-1:0] CI_THRESHOLD = 8'd128;

    // ni counts over all 8 neighbours, so it doubles as the neighbour count
    localparam int NI_MAX = 8;
    localparam logic [FEAT_W-1:0] RD_MAX = 4'd9;
    localparam int RD_SHIFT = 6;
    localparam int SUM_W = 11;

    // histogram
    localparam int NUM_BINS = 200;
    localparam int BIN_IDX_W = 8;
    localparam int COUNT_W = 16;
    localparam logic [BIN_IDX_W-1:0] LAST_BIN = BIN_IDX_W'(NUM_BINS - 1);

    // frame sequencing
    localparam int WIN_PER_FRAME = (IMG_W - 2) * (IMG_H - 2);
    localparam int WIN_CNT_W = 6;
    localparam int DRAIN_CYCLES = 2;

    typedef enum logic [1:0] {
        PH_ACCUM,
        PH_DRAIN,
        PH_READ
    } phase_t;

endpackage

/* window_gen.sv */
`timescale 1ns/1ps

module window_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pix_valid_i,
    input  logic                       accept_i,
    input  logic [hist_pkg::PIX_W-1:0] pix_i,
    output logic                       win_valid_o,
    output logic [hist_pkg::PIX_W-1:0] w00_o,
    output logic [hist_pkg::PIX_W-1:0] w01_o,
    output logic [hist_pkg::PIX_W-1:0] w02_o,
    output logic [hist_pkg::PIX_W-1:0] w10_o,
    output logic [hist_pkg::PIX_W-1:0] w11_o,
    output logic [hist_pkg::PIX_W-1:0] w12_o,
    output logic [hist_pkg::PIX_W-1:0] w20_o,
    output logic [hist_pkg::PIX_W-1:0] w21_o,
    output logic [hist_pkg::PIX_W-1:0] w22_o
);

    // line1 holds the previous row, line2 the row before it
    logic [hist_pkg::PIX_W-1:0] line1_mem [hist_pkg::IMG_W];
    logic [hist_pkg::PIX_W-1:0] line2_mem [hist_pkg::IMG_W];
    logic [hist_pkg::POS_W-1:0] col_q;
    logic [hist_pkg::POS_W-1:0] row_q;
    logic                       take;
    logic [hist_pkg::PIX_W-1:0] up1_pix;
    logic [hist_pkg::PIX_W-1:0] up2_pix;

    assign take    = pix_valid_i && accept_i;
    assign up1_pix = line1_mem[col_q];
    assign up2_pix = line2_mem[col_q];

    // column history moves up one row per accepted pixel
    always_ff @(posedge clk) begin
        if (take) begin
            line2_mem[col_q] <= up1_pix;
            line1_mem[col_q] <= pix_i;
        end
    end

    // new column enters on the right
    always_ff @(posedge clk) begin
        if (take) begin
            w00_o <= w01_o;
            w01_o <= w02_o;
            w02_o <= up2_pix;
            w10_o <= w11_o;
            w11_o <= w12_o;
            w12_o <= up1_pix;
            w20_o <= w21_o;
            w21_o <= w22_o;
            w22_o <= pix_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_q       <= '0;
            row_q       <= '0;
            win_valid_o <= 1'b0;
        end else begin
            // window is interior once two rows and two columns are behind it
            win_valid_o <= take && (row_q >= 2) && (col_q >= 2);
            if (take) begin
                if (col_q == hist_pkg::LAST_COL) begin
                    col_q <= '0;
                    row_q <= (row_q == hist_pkg::LAST_ROW) ? '0 : row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

endmodule

/* sign_pattern_unit.sv */
`timescale 1ns/1ps

module sign_pattern_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        win_valid_i,
    input  logic [hist_pkg::PIX_W-1:0]  w00_i,
    input  logic [hist_pkg::PIX_W-1:0]  w01_i,
    input  logic [hist_pkg::PIX_W-1:0]  w02_i,
    input  logic [hist_pkg::PIX_W-1:0]  w10_i,
    input  logic [hist_pkg::PIX_W-1:0]  w11_i,
    input  logic [hist_pkg::PIX_W-1:0]  w12_i,
    input  logic [hist_pkg::PIX_W-1:0]  w20_i,
    input  logic [hist_pkg::PIX_W-1:0]  w21_i,
    input  logic [hist_pkg::PIX_W-1:0]  w22_i,
    output logic                        feat_valid_o,
    output logic                        ci_o,
    output logic [hist_pkg::FEAT_W-1:0] ni_o
);

    logic [hist_pkg::PIX_W-1:0]  nb [hist_pkg::NI_MAX];
    logic [hist_pkg::NI_MAX-1:0] ge_q;
    logic                        thr_q;
    logic                        s1_valid_q;

    function automatic logic [hist_pkg::FEAT_W-1:0] popcount(
        input logic [hist_pkg::NI_MAX-1:0] bits
    );
        logic [hist_pkg::FEAT_W-1:0] cnt;
        cnt = '0;
        for (int k = 0; k < hist_pkg::NI_MAX; k++) begin
            cnt = cnt + {{(hist_pkg::FEAT_W-1){1'b0}}, bits[k]};
        end
        return cnt;
    endfunction

    assign nb = '{w00_i, w01_i, w02_i, w10_i, w12_i, w20_i, w21_i, w22_i};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q   <= 1'b0;
            feat_valid_o <= 1'b0;
        end else begin
            s1_valid_q   <= win_valid_i;
            feat_valid_o <= s1_valid_q;
        end
    end

    // stage 1: neighbour vs centre, centre vs threshold
    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            for (int k = 0; k < hist_pkg::NI_MAX; k++) begin
                ge_q[k] <= (nb[k] >= w11_i);
            end
            thr_q <= (w11_i >= hist_pkg::CI_THRESHOLD);
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            ni_o <= popcount(ge_q);
            ci_o <= thr_q;
        end
    end

endmodule

/* magnitude_pattern_unit.sv */
`timescale 1ns/1ps

module magnitude_pattern_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        win_valid_i,
    input  logic [hist_pkg::PIX_W-1:0]  w00_i,
    input  logic [hist_pkg::PIX_W-1:0]  w01_i,
    input  logic [hist_pkg::PIX_W-1:0]  w02_i,
    input  logic [hist_pkg::PIX_W-1:0]  w10_i,
    input  logic [hist_pkg::PIX_W-1:0]  w11_i,
    input  logic [hist_pkg::PIX_W-1:0]  w12_i,
    input  logic [hist_pkg::PIX_W-1:0]  w20_i,
    input  logic [hist_pkg::PIX_W-1:0]  w21_i,
    input  logic [hist_pkg::PIX_W-1:0]  w22_i,
    output logic [hist_pkg::FEAT_W-1:0] rd_o
);

    logic [hist_pkg::PIX_W-1:0] nb [hist_pkg::NI_MAX];
    logic [hist_pkg::PIX_W-1:0] diff_q [hist_pkg::NI_MAX];
    logic                       s1_valid_q;
    logic [hist_pkg::SUM_W-1:0] diff_sum;
    logic [hist_pkg::SUM_W-1:0] sum_shr;

    function automatic logic [hist_pkg::PIX_W-1:0] abs_diff(
        input logic [hist_pkg::PIX_W-1:0] a,
        input logic [hist_pkg::PIX_W-1:0] b
    );
        return (a >= b) ? a - b : b - a;
    endfunction

    assign nb = '{w00_i, w01_i, w02_i, w10_i, w12_i, w20_i, w21_i, w22_i};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= win_valid_i;
        end
    end

    // stage 1: absolute differences from centre
    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            for (int k = 0; k < hist_pkg::NI_MAX; k++) begin
                diff_q[k] <= abs_diff(nb[k], w11_i);
            end
        end
    end

    // sum of eight diffs fits in 11 bits
    always_comb begin
        diff_sum = '0;
        for (int k = 0; k < hist_pkg::NI_MAX; k++) begin
            diff_sum = diff_sum + {{(hist_pkg::SUM_W-hist_pkg::PIX_W){1'b0}}, diff_q[k]};
        end
        sum_shr = diff_sum >> hist_pkg::RD_SHIFT;
    end

    // stage 2: quantise and clamp, rd holds between features
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            if (sum_shr > hist_pkg::RD_MAX) begin
                rd_o <= hist_pkg::RD_MAX;
            end else begin
                rd_o <= sum_shr[hist_pkg::FEAT_W-1:0];
            end
        end
    end

endmodule

/* joint_histogram.sv */
`timescale 1ns/1ps

module joint_histogram (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           feat_valid_i,
    input  logic                           ci_i,
    input  logic [hist_pkg::FEAT_W-1:0]    ni_i,
    input  logic [hist_pkg::FEAT_W-1:0]    rd_i,
    input  logic                           count_en_i,
    input  logic                           read_en_i,
    output logic                           bin_valid_o,
    output logic [hist_pkg::BIN_IDX_W-1:0] bin_index_o,
    output logic [hist_pkg::COUNT_W-1:0]   bin_count_o,
    output logic                           hist_done_o
);

    logic [hist_pkg::COUNT_W-1:0]   bin_mem [hist_pkg::NUM_BINS];
    logic [hist_pkg::BIN_IDX_W-1:0] ci_ext;
    logic [hist_pkg::BIN_IDX_W-1:0] ni_ext;
    logic [hist_pkg::BIN_IDX_W-1:0] rd_ext;
    logic [hist_pkg::BIN_IDX_W-1:0] feat_idx;
    logic                           inc_go;
    logic                           inc_pend_q;
    logic [hist_pkg::BIN_IDX_W-1:0] inc_idx_q;
    logic [hist_pkg::COUNT_W-1:0]   inc_cnt_q;
    logic                           read_go;
    logic [hist_pkg::BIN_IDX_W-1:0] rd_ptr_q;

    assign ci_ext = {{(hist_pkg::BIN_IDX_W-1){1'b0}}, ci_i};
    assign ni_ext = {{(hist_pkg::BIN_IDX_W-hist_pkg::FEAT_W){1'b0}}, ni_i};
    assign rd_ext = {{(hist_pkg::BIN_IDX_W-hist_pkg::FEAT_W){1'b0}}, rd_i};

    // ci*100 + ni*10 + rd as shift-and-add
    assign feat_idx = (ci_ext << 6) + (ci_ext << 5) + (ci_ext << 2)
                    + (ni_ext << 3) + (ni_ext << 1) + rd_ext;

    assign inc_go  = feat_valid_i && count_en_i;
    // no bin in the cycle after 199, read_en drops on that edge
    assign read_go = read_en_i && !hist_done_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inc_pend_q  <= 1'b0;
            rd_ptr_q    <= '0;
            bin_valid_o <= 1'b0;
            hist_done_o <= 1'b0;
        end else begin
            inc_pend_q  <= inc_go;
            bin_valid_o <= read_go;
            hist_done_o <= read_go && (rd_ptr_q == hist_pkg::LAST_BIN);
            if (read_go) begin
                rd_ptr_q <= (rd_ptr_q == hist_pkg::LAST_BIN) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // read stage of the increment, forward when the same bin is in flight
    always_ff @(posedge clk) begin
        if (inc_go) begin
            inc_idx_q <= feat_idx;
            if (inc_pend_q && (feat_idx == inc_idx_q)) begin
                inc_cnt_q <= inc_cnt_q + 1'b1;
            end else begin
                inc_cnt_q <= bin_mem[feat_idx];
            end
        end
        if (read_go) begin
            bin_index_o <= rd_ptr_q;
            bin_count_o <= bin_mem[rd_ptr_q];
        end
    end

    // write stage, read-out clears the bin it emits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < hist_pkg::NUM_BINS; i++) begin
                bin_mem[i] <= '0;
            end
        end else if (inc_pend_q) begin
            bin_mem[inc_idx_q] <= inc_cnt_q + 1'b1;
        end else if (read_go) begin
            bin_mem[rd_ptr_q] <= '0;
        end
    end

endmodule

/* frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic feat_valid_i,
    input  logic hist_done_i,
    output logic accept_o,
    output logic count_en_o,
    output logic read_en_o
);

    hist_pkg::phase_t               phase_q;
    logic [hist_pkg::WIN_CNT_W-1:0] feat_cnt_q;
    logic [1:0]                     drain_cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q     <= hist_pkg::PH_ACCUM;
            feat_cnt_q  <= '0;
            drain_cnt_q <= '0;
        end else begin
            case (phase_q)
                hist_pkg::PH_ACCUM: begin
                    if (feat_valid_i) begin
                        if (feat_cnt_q == hist_pkg::WIN_PER_FRAME - 1) begin
                            feat_cnt_q  <= '0;
                            drain_cnt_q <= '0;
                            phase_q     <= hist_pkg::PH_DRAIN;
                        end else begin
                            feat_cnt_q <= feat_cnt_q + 1'b1;
                        end
                    end
                end
                // let the last increment reach the counter memory
                hist_pkg::PH_DRAIN: begin
                    if (drain_cnt_q == hist_pkg::DRAIN_CYCLES - 1) begin
                        phase_q <= hist_pkg::PH_READ;
                    end else begin
                        drain_cnt_q <= drain_cnt_q + 1'b1;
                    end
                end
                hist_pkg::PH_READ: begin
                    if (hist_done_i) begin
                        phase_q <= hist_pkg::PH_ACCUM;
                    end
                end
                default: phase_q <= hist_pkg::PH_ACCUM;
            endcase
        end
    end

    assign accept_o   = (phase_q == hist_pkg::PH_ACCUM);
    assign count_en_o = (phase_q == hist_pkg::PH_ACCUM);
    assign read_en_o  = (phase_q == hist_pkg::PH_READ);

endmodule

/* texture_hist_top.sv */
`timescale 1ns/1ps

module texture_hist_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pix_valid_i,
    input  logic [hist_pkg::PIX_W-1:0]     pix_i,
    output logic                           bin_valid_o,
    output logic [hist_pkg::BIN_IDX_W-1:0] bin_index_o,
    output logic [hist_pkg::COUNT_W-1:0]   bin_count_o,
    output logic                           hist_done_o
);

    logic                        accept;
    logic                        count_en;
    logic                        read_en;
    logic                        win_valid;
    logic [hist_pkg::PIX_W-1:0]  w00, w01, w02, w10, w11, w12, w20, w21, w22;
    logic                        feat_valid;
    logic                        ci;
    logic [hist_pkg::FEAT_W-1:0] ni;
    logic [hist_pkg::FEAT_W-1:0] rd;

    window_gen u_window_gen (
        .clk(clk), .rst_n(rst_n), .pix_valid_i(pix_valid_i), .accept_i(accept),
        .pix_i(pix_i), .win_valid_o(win_valid),
        .w00_o(w00), .w01_o(w01), .w02_o(w02),
        .w10_o(w10), .w11_o(w11), .w12_o(w12),
        .w20_o(w20), .w21_o(w21), .w22_o(w22)
    );

    // both feature units see the same window
    sign_pattern_unit u_sign (
        .clk(clk), .rst_n(rst_n), .win_valid_i(win_valid),
        .w00_i(w00), .w01_i(w01), .w02_i(w02),
        .w10_i(w10), .w11_i(w11), .w12_i(w12),
        .w20_i(w20), .w21_i(w21), .w22_i(w22),
        .feat_valid_o(feat_valid), .ci_o(ci), .ni_o(ni)
    );

    magnitude_pattern_unit u_magnitude (
        .clk(clk), .rst_n(rst_n), .win_valid_i(win_valid),
        .w00_i(w00), .w01_i(w01), .w02_i(w02),
        .w10_i(w10), .w11_i(w11), .w12_i(w12),
        .w20_i(w20), .w21_i(w21), .w22_i(w22),
        .rd_o(rd)
    );

    joint_histogram u_hist (
        .clk(clk), .rst_n(rst_n), .feat_valid_i(feat_valid),
        .ci_i(ci), .ni_i(ni), .rd_i(rd),
        .count_en_i(count_en), .read_en_i(read_en),
        .bin_valid_o(bin_valid_o), .bin_index_o(bin_index_o),
        .bin_count_o(bin_count_o), .hist_done_o(hist_done_o)
    );

    frame_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .feat_valid_i(feat_valid), .hist_done_i(hist_done_o),
        .accept_o(accept), .count_en_o(count_en), .read_en_o(read_en)
    );

endmodule

/* tb_texture_hist.sv */
`timescale 1ns/1ps

module tb_texture_hist;

    localparam int NUM_FRAMES = 5;
    localparam int FRAME_PIX = hist_pkg::IMG_W * hist_pkg::IMG_H;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (FRAME_PIX + hist_pkg::NUM_BINS + 20) * 4;

    logic                           clk;
    logic                           rst_n;
    logic                           pix_valid_i;
    logic [hist_pkg::PIX_W-1:0]     pix_i;
    logic                           bin_valid_o;
    logic [hist_pkg::BIN_IDX_W-1:0] bin_index_o;
    logic [hist_pkg::COUNT_W-1:0]   bin_count_o;
    logic                           hist_done_o;

    int                         seed;
    int                         value_errors;
    int                         other_errors;
    logic [hist_pkg::PIX_W-1:0] frame_pix [FRAME_PIX];
    int                         exp_hist [hist_pkg::NUM_BINS];
    int                         exp_idx;
    int                         frame_sum;
    int                         frames_read;
    logic                       armed;

    texture_hist_top uut (
        .clk(clk), .rst_n(rst_n), .pix_valid_i(pix_valid_i), .pix_i(pix_i),
        .bin_valid_o(bin_valid_o), .bin_index_o(bin_index_o),
        .bin_count_o(bin_count_o), .hist_done_o(hist_done_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_value(input string name, input int expected, input int actual);
        value_errors++;
        $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    endtask

    task automatic report_other(input string what);
        other_errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic print_counts();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

    task automatic fill_constant(input int value);
        for (int i = 0; i < FRAME_PIX; i++) begin
            frame_pix[i] = 8'(value);
        end
    endtask

    // base plus masked random bits, small masks give low contrast
    task automatic fill_random(input int base, input int mask);
        for (int i = 0; i < FRAME_PIX; i++) begin
            frame_pix[i] = 8'(base + ($random(seed) & mask));
        end
    endtask

    task automatic expect_single_bin(input int bin);
        for (int i = 0; i < hist_pkg::NUM_BINS; i++) begin
            exp_hist[i] = 0;
        end
        exp_hist[bin] = hist_pkg::WIN_PER_FRAME;
    endtask

    // features of every interior pixel, straight from the frame copy
    task automatic build_model();
        int centre;
        int nb;
        int ni;
        int sum;
        int rd;
        int ci;
        for (int i = 0; i < hist_pkg::NUM_BINS; i++) begin
            exp_hist[i] = 0;
        end
        for (int r = 1; r < hist_pkg::IMG_H - 1; r++) begin
            for (int c = 1; c < hist_pkg::IMG_W - 1; c++) begin
                centre = int'(frame_pix[r * hist_pkg::IMG_W + c]);
                ni = 0;
                sum = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (dr != 0 || dc != 0) begin
                            nb = int'(frame_pix[(r + dr) * hist_pkg::IMG_W + c + dc]);
                            if (nb >= centre) ni++;
                            sum += (nb > centre) ? nb - centre : centre - nb;
                        end
                    end
                end
                ci = (centre >= int'(hist_pkg::CI_THRESHOLD)) ? 1 : 0;
                rd = sum >> hist_pkg::RD_SHIFT;
                if (rd > int'(hist_pkg::RD_MAX)) rd = int'(hist_pkg::RD_MAX);
                exp_hist[ci * 100 + ni * 10 + rd]++;
            end
        end
    endtask

    // raster order with an idle cycle now and then
    task automatic send_frame();
        for (int i = 0; i < FRAME_PIX; i++) begin
            @(negedge clk);
            if (($random(seed) & 3) == 0) begin
                pix_valid_i = 1'b0;
                @(negedge clk);
            end
            pix_valid_i = 1'b1;
            pix_i = frame_pix[i];
        end
        @(negedge clk);
        pix_valid_i = 1'b0;
        armed = 1'b1;
    endtask

    // junk pixels during read-out must be dropped by the DUT
    task automatic wait_readout(input bit junk);
        int rnd;
        while (!bin_valid_o) @(negedge clk);
        while (bin_valid_o) begin
            if (junk) begin
                rnd = $random(seed);
                pix_valid_i = rnd[0];
                pix_i = rnd[15:8];
            end
            @(negedge clk);
        end
        pix_valid_i = 1'b0;
        assert (exp_idx == 0) else report_other("read-out stopped before bin 199");
    endtask

    task automatic run_frame(input bit junk);
        send_frame();
        wait_readout(junk);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (bin_valid_o) begin
                assert (armed) else report_other("bin_valid_o high with no frame completed");
                assert (int'(bin_index_o) == exp_idx)
                    else report_value("bin_index_o", exp_idx, int'(bin_index_o));
                assert (int'(bin_count_o) == exp_hist[exp_idx])
                    else report_value("bin_count_o", exp_hist[exp_idx], int'(bin_count_o));
                assert (hist_done_o == (exp_idx == hist_pkg::NUM_BINS - 1))
                    else report_value("hist_done_o", int'(exp_idx == hist_pkg::NUM_BINS - 1),
                                      int'(hist_done_o));
                frame_sum += int'(bin_count_o);
                if (exp_idx == hist_pkg::NUM_BINS - 1) begin
                    assert (frame_sum == hist_pkg::WIN_PER_FRAME)
                        else report_value("bin count sum", hist_pkg::WIN_PER_FRAME, frame_sum);
                    exp_idx = 0;
                    frame_sum = 0;
                    armed = 1'b0;
                    frames_read++;
                end else begin
                    exp_idx++;
                end
            end else begin
                assert (!hist_done_o) else report_other("hist_done_o high without bin_valid_o");
            end
        end
    end

    initial begin
        seed = 32'hf45a_274f;
        rst_n = 1'b0;
        pix_valid_i = 1'b0;
        pix_i = '0;
        value_errors = 0;
        other_errors = 0;
        exp_idx = 0;
        frame_sum = 0;
        frames_read = 0;
        armed = 1'b0;
        expect_single_bin(0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);

        // flat frames: ci from level, all neighbours equal, no difference
        fill_constant(200);
        expect_single_bin(180);
        run_frame(1'b0);
        fill_constant(50);
        expect_single_bin(80);
        run_frame(1'b0);

        fill_random(0, 255);
        build_model();
        run_frame(1'b0);
        fill_random(0, 255);
        build_model();
        run_frame(1'b1);
        // low contrast gives long runs on one bin
        fill_random(100, 3);
        build_model();
        run_frame(1'b0);

        assert (frames_read == NUM_FRAMES) else report_other("not every frame was read out");
        print_counts();
        if (value_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_other("timeout, the frames did not all complete");
        print_counts();
        $display("Verification failed");
        $finish;
    end

endmodule

/* sources.f */
hist_pkg.sv
window_gen.sv
sign_pattern_unit.sv
magnitude_pattern_unit.sv
joint_histogram.sv
frame_sequencer.sv
texture_hist_top.sv
tb_texture_hist.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the texture histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_texture_hist -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0
